// File: tb.f
src/motor_pkg.sv
src/spi_master.sv
src/driver_setup.sv
src/step_generator.sv
src/motor_driver.sv
dv/motor_driver_sva.sv
dv/tb_motor_driver.sv

// File: Makefile
TOOL       := verilator
FLAGS      := --binary --assert
LINT_FLAGS := --lint-only -Wall --timing --assert
TOP        := tb_motor_driver
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_motor_driver.sv
module tb_motor_driver;
  import motor_pkg::*;

  localparam int CS_WIDTH     = 12;
  localparam int CS_INDEX     = 0;
  localparam int SCLK_HALF    = 8;
  localparam int SETUP_FRAMES = 6;
  localparam int SEGMENTS     = 20;

  // Covers six frames of about 660 cycles and twenty segments of up to 201 cycles with margin
  localparam int TIMEOUT_CYCLES = 12000;

  // Two frame lengths of silence are enough to catch a stray seventh frame
  localparam int QUIET_CYCLES = 2 * (2 * SCLK_HALF * FRAME_BITS + 4);

  logic                clk_in         = 1'b0;
  logic                reset_n_in     = 1'b0;
  logic                miso_in        = 1'b0;
  logic                step_enable_in = 1'b0;
  speed_t              speed_in       = '0;
  logic                sclk_out;
  logic                mosi_out;
  logic [CS_WIDTH-1:0] cs_n_out;
  logic                step_out;
  status_t             status_out;
  logic                setup_done_out;

  integer seed        = 32'hbad8;
  int     spi_errors  = 0;
  int     step_errors = 0;
  int     end_errors  = 0;
  int     cycle_count = 0;
  int     frames_seen = 0;

  // Driver chip model state
  frame_t  reply_words [0:7];
  frame_t  reply          = '0;
  frame_t  rx_word        = '0;
  status_t exp_status     = '0;
  logic    cs_prev        = 1'b1;
  logic    sclk_prev      = 1'b1;
  logic    status_pending = 1'b0;
  logic    done_seen      = 1'b0;
  int      fall_count     = 0;
  int      bit_count      = 0;

  // Step checker state
  logic   prev_en   = 1'b0;
  logic   exp_step  = 1'b0;
  longint run_len   = 0;
  longint run_speed = 0;

  motor_driver #(
    .CS_WIDTH  (CS_WIDTH),
    .CS_INDEX  (CS_INDEX),
    .SCLK_HALF (SCLK_HALF)
  ) u_motor_driver (
    .clk_in         (clk_in),
    .reset_n_in     (reset_n_in),
    .miso_in        (miso_in),
    .step_enable_in (step_enable_in),
    .speed_in       (speed_in),
    .sclk_out       (sclk_out),
    .mosi_out       (mosi_out),
    .cs_n_out       (cs_n_out),
    .step_out       (step_out),
    .status_out     (status_out),
    .setup_done_out (setup_done_out)
  );

  always #5 clk_in = ~clk_in;

  task automatic print_error_counts();
    $display("Errors: spi %0d, step %0d, end of run %0d, total %0d",
             spi_errors, step_errors, end_errors, spi_errors + step_errors + end_errors);
  endtask

  // Each frame gets one reply and spares cover any extra frames that show up
  task automatic make_replies();
    logic [31:0] hi;
    logic [31:0] lo;
    for (int i = 0; i < 8; i++) begin
      hi = $random(seed);
      lo = $random(seed);
      reply_words[i] = {hi[7:0], lo};
    end
  endtask

  // A single disabled cycle carries the new speed, so each run has a constant speed
  task automatic drive_step_segment();
    logic [31:0] r;
    int          len;
    r = $random(seed);
    len = 20 + int'(r[15:8]) % 181;
    step_enable_in <= 1'b0;
    speed_in       <= {60'd0, r[3:0]};
    @(posedge clk_in);
    step_enable_in <= r[16];
    repeat (len) @(posedge clk_in);
  endtask

  always @(posedge clk_in) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycle_count);
      print_error_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // The driver chip model works on values sampled at the system clock edge
  always @(posedge clk_in) begin
    if (!reset_n_in) begin
      cs_prev        = 1'b1;
      sclk_prev      = 1'b1;
      status_pending = 1'b0;
      frames_seen    = 0;
    end else begin
      if (cs_n_out[CS_WIDTH-1:1] != {(CS_WIDTH-1){1'b1}}) begin
        spi_errors++;
        $display("mismatch cs_n_out[11:1]: got 0x%h expected 0x%h",
                 cs_n_out[CS_WIDTH-1:1], {(CS_WIDTH-1){1'b1}});
      end
      if (cs_n_out == {CS_WIDTH{1'b1}} && !sclk_out) begin
        spi_errors++;
        $display("mismatch sclk_out: got 0x%h expected 0x1 with no select active", sclk_out);
      end

      if (status_pending) begin
        status_pending = 1'b0;
        if (status_out !== exp_status) begin
          spi_errors++;
          $display("mismatch status_out: got 0x%h expected 0x%h", status_out, exp_status);
        end
        if (frames_seen == SETUP_FRAMES && setup_done_out !== 1'b1) begin
          spi_errors++;
          $display("mismatch setup_done_out: got 0x%h expected 0x1", setup_done_out);
        end
      end
      if (frames_seen < SETUP_FRAMES && setup_done_out !== 1'b0) begin
        spi_errors++;
        $display("mismatch setup_done_out: got 0x%h expected 0x0 before frame 6 ended",
                 setup_done_out);
      end
      if (done_seen && setup_done_out !== 1'b1) begin
        spi_errors++;
        $display("mismatch setup_done_out: got 0x%h expected 0x1 after setup", setup_done_out);
      end
      if (setup_done_out) begin
        done_seen = 1'b1;
      end

      if (cs_prev && !cs_n_out[0]) begin
        reply      = reply_words[(frames_seen < 8) ? frames_seen : 7];
        rx_word    = '0;
        fall_count = 0;
        bit_count  = 0;
      end
      // Reply bits change on falling sclk with the MSB first
      if (!cs_n_out[0] && sclk_prev && !sclk_out) begin
        if (fall_count < FRAME_BITS) begin
          miso_in <= reply[FRAME_BITS-1-fall_count];
        end
        fall_count++;
      end
      if (!cs_n_out[0] && !sclk_prev && sclk_out) begin
        rx_word = {rx_word[FRAME_BITS-2:0], mosi_out};
        bit_count++;
      end
      if (!cs_prev && cs_n_out[0]) begin
        if (bit_count != FRAME_BITS) begin
          spi_errors++;
          $display("Frame %0d carried %0d sclk rising edges instead of %0d",
                   frames_seen, bit_count, FRAME_BITS);
        end
        if (frames_seen < SETUP_FRAMES) begin
          if (rx_word !== SETUP_WORDS[frames_seen]) begin
            spi_errors++;
            $display("mismatch mosi_out frame %0d: got 0x%h expected 0x%h",
                     frames_seen, rx_word, SETUP_WORDS[frames_seen]);
          end
          exp_status     = reply[FRAME_BITS-1 -: 8];
          status_pending = 1'b1;
        end else begin
          spi_errors++;
          $display("Unexpected frame %0d arrived after the setup sequence", frames_seen);
        end
        frames_seen++;
      end
      cs_prev   = cs_n_out[0];
      sclk_prev = sclk_out;
    end
  end

  // After n enabled cycles the step level has toggled once per speed+1 cycles,
  // and the pin shows it one cycle later, so the first rise lands speed+2 after enable
  always @(posedge clk_in) begin
    if (!reset_n_in) begin
      prev_en = 1'b0;
      run_len = 0;
    end else begin
      exp_step = prev_en && ((((run_len - 1) / (run_speed + 1)) % 2) == 1);
      if (step_out !== exp_step) begin
        step_errors++;
        $display("mismatch step_out: got 0x%h expected 0x%h at cycle %0d",
                 step_out, exp_step, cycle_count);
      end
      if (step_enable_in) begin
        if (!prev_en) begin
          run_speed = longint'(speed_in);
        end
        run_len++;
      end else begin
        run_len = 0;
      end
      prev_en = step_enable_in;
    end
  end

  initial begin
    make_replies();
    repeat (2) @(posedge clk_in);
    reset_n_in <= 1'b1;
    for (int seg = 0; seg < SEGMENTS; seg++) begin
      drive_step_segment();
    end
    step_enable_in <= 1'b0;
    while (!setup_done_out) begin
      @(posedge clk_in);
    end
    repeat (QUIET_CYCLES) @(posedge clk_in);
    if (frames_seen != SETUP_FRAMES) begin
      end_errors++;
      $display("Expected %0d setup frames but the chip model saw %0d",
               SETUP_FRAMES, frames_seen);
    end
    print_error_counts();
    if (spi_errors + step_errors + end_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/motor_driver_sva.sv
module motor_driver_sva #(
  parameter int CS_WIDTH = 12,
  parameter int CS_INDEX = 0
) (
  input logic                clk_in,
  input logic                reset_n_in,
  input logic [CS_WIDTH-1:0] cs_n_out,
  input logic                sclk_out,
  input logic                step_enable_in,
  input logic                step_out
);

  // Every select line except the one in use
  localparam logic [CS_WIDTH-1:0] OTHER_SELECTS = ~(CS_WIDTH'(1) << CS_INDEX);

  one_select_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    $countones(~cs_n_out) <= 1)
    else $error("more than one cs_n line is low: %h", cs_n_out);

  // Mode 3 keeps sclk high between frames
  sclk_idle_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    (&cs_n_out) |-> sclk_out)
    else $error("sclk_out is low while no cs_n line is active");

  step_gate_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    !step_enable_in |=> !step_out)
    else $error("step_out is high one cycle after step_enable_in was low");

  other_selects_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    (cs_n_out & OTHER_SELECTS) == OTHER_SELECTS)
    else $error("an unused cs_n line went low: %h", cs_n_out);

endmodule

bind motor_driver motor_driver_sva #(
  .CS_WIDTH (CS_WIDTH),
  .CS_INDEX (CS_INDEX)
) u_motor_driver_sva (
  .clk_in         (clk_in),
  .reset_n_in     (reset_n_in),
  .cs_n_out       (cs_n_out),
  .sclk_out       (sclk_out),
  .step_enable_in (step_enable_in),
  .step_out       (step_out)
);

// File: src/motor_driver.sv
module motor_driver #(
  parameter int CS_WIDTH  = 12,
  parameter int CS_INDEX  = 0,
  parameter int SCLK_HALF = 8
) (
  input  logic                clk_in,
  input  logic                reset_n_in,
  input  logic                miso_in,
  input  logic                step_enable_in,
  input  motor_pkg::speed_t   speed_in,
  output logic                sclk_out,
  output logic                mosi_out,
  output logic [CS_WIDTH-1:0] cs_n_out,
  output logic                step_out,
  output motor_pkg::status_t  status_out,
  output logic                setup_done_out
);
  import motor_pkg::*;

  logic   start;
  logic   busy;
  frame_t tx_frame;
  frame_t rx_frame;

  // Register setup sequence runs once after reset
  driver_setup u_setup (
    .clk_in         (clk_in),
    .reset_n_in     (reset_n_in),
    .busy_in        (busy),
    .rx_frame_in    (rx_frame),
    .start_out      (start),
    .tx_frame_out   (tx_frame),
    .status_out     (status_out),
    .setup_done_out (setup_done_out)
  );

  // About 3 MHz SPI clock from 50 MHz with the default half period
  spi_master #(
    .CS_WIDTH  (CS_WIDTH),
    .CS_INDEX  (CS_INDEX),
    .SCLK_HALF (SCLK_HALF)
  ) u_spi (
    .clk_in       (clk_in),
    .reset_n_in   (reset_n_in),
    .start_in     (start),
    .tx_frame_in  (tx_frame),
    .miso_in      (miso_in),
    .busy_out     (busy),
    .rx_frame_out (rx_frame),
    .sclk_out     (sclk_out),
    .mosi_out     (mosi_out),
    .cs_n_out     (cs_n_out)
  );

  // Step pulses are independent of the setup progress
  step_generator u_step (
    .clk_in         (clk_in),
    .reset_n_in     (reset_n_in),
    .step_enable_in (step_enable_in),
    .speed_in       (speed_in),
    .step_out       (step_out)
  );

endmodule

// File: src/step_generator.sv
module step_generator (
  input  logic              clk_in,
  input  logic              reset_n_in,
  input  logic              step_enable_in,
  input  motor_pkg::speed_t speed_in,
  output logic              step_out
);
  import motor_pkg::*;

  speed_t count;
  logic   step_level;
  logic   wrap;

  assign wrap = (count == speed_in);

  // Divider runs only while enabled so each enabled stretch starts on a full period
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      count      <= '0;
      step_level <= 1'b0;
    end else if (!step_enable_in) begin
      count      <= '0;
      step_level <= 1'b0;
    end else if (wrap) begin
      count      <= '0;
      step_level <= ~step_level;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Output stage drops the pin one clock after the enable goes away
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      step_out <= 1'b0;
    end else begin
      step_out <= step_level && step_enable_in;
    end
  end

endmodule

// File: src/driver_setup.sv
module driver_setup (
  input  logic               clk_in,
  input  logic               reset_n_in,
  input  logic               busy_in,
  input  motor_pkg::frame_t  rx_frame_in,
  output logic               start_out,
  output motor_pkg::frame_t  tx_frame_out,
  output motor_pkg::status_t status_out,
  output logic               setup_done_out
);
  import motor_pkg::*;

  setup_state_t state;
  logic         busy_q;
  logic         kickoff;
  logic         busy_fall;
  logic         advance;
  logic         last_word;

  // A frame has ended when busy drops
  assign busy_fall = busy_q && !busy_in;
  assign advance   = busy_fall && (state != setup_done);
  assign last_word = (state == pwm_conf);

  // The word follows the state and only changes once busy has dropped
  assign tx_frame_out = (state == setup_done) ? '0 : SETUP_WORDS[state];

  assign setup_done_out = (state == setup_done);

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state      <= chop_conf;
      busy_q     <= 1'b0;
      kickoff    <= 1'b1;
      start_out  <= 1'b0;
      status_out <= '0;
    end else begin
      busy_q  <= busy_in;
      kickoff <= 1'b0;

      // First frame goes out right after reset and each later one after the previous ends
      start_out <= kickoff || (advance && !last_word);

      if (advance) begin
        state      <= setup_state_t'(state + 3'd1);
        status_out <= rx_frame_in[FRAME_BITS-1 -: $bits(status_t)];
      end
    end
  end

endmodule

// File: src/spi_master.sv
module spi_master #(
  parameter int CS_WIDTH  = 12,
  parameter int CS_INDEX  = 0,
  parameter int SCLK_HALF = 8
) (
  input  logic                clk_in,
  input  logic                reset_n_in,
  input  logic                start_in,
  input  motor_pkg::frame_t   tx_frame_in,
  input  logic                miso_in,
  output logic                busy_out,
  output motor_pkg::frame_t   rx_frame_out,
  output logic                sclk_out,
  output logic                mosi_out,
  output logic [CS_WIDTH-1:0] cs_n_out
);
  import motor_pkg::*;

  localparam int HALF_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
  localparam int BIT_W  = $clog2(FRAME_BITS);

  typedef enum logic [1:0] {
    idle,
    shift,
    finish
  } spi_state_t;

  spi_state_t        state;
  logic [HALF_W-1:0] half_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  frame_t            shift_reg;
  logic              half_done;
  logic              last_bit;
  logic              launch;
  logic              rise_edge;

  assign half_done = (half_cnt == HALF_W'(SCLK_HALF - 1));
  assign last_bit  = (bit_cnt == BIT_W'(FRAME_BITS - 1));
  assign launch    = (state == idle) && start_in;

  // sclk is still low in the cycle that ends a low half period
  assign rise_edge = (state == shift) && half_done && !sclk_out;

  assign busy_out     = (state != idle);
  assign rx_frame_out = shift_reg;

  // Transfer control with sclk idling high as mode 3 requires
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state    <= idle;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk_out <= 1'b1;
      mosi_out <= 1'b0;
      cs_n_out <= '1;
    end else begin
      case (state)
        idle: begin
          if (start_in) begin
            state              <= shift;
            half_cnt           <= '0;
            bit_cnt            <= '0;
            cs_n_out[CS_INDEX] <= 1'b0;
          end
        end

        shift: begin
          if (half_done) begin
            half_cnt <= '0;
            sclk_out <= ~sclk_out;
            if (sclk_out) begin
              // Falling edge presents the next bit MSB first
              mosi_out <= shift_reg[FRAME_BITS-1];
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              if (last_bit) begin
                state <= finish;
              end
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end

        finish: begin
          // The chip latches the write when its select returns high
          state    <= idle;
          cs_n_out <= '1;
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // One register serves both directions
  // The top bit has already been driven by the time miso enters at the bottom
  always_ff @(posedge clk_in) begin
    if (launch) begin
      shift_reg <= tx_frame_in;
    end else if (rise_edge) begin
      shift_reg <= {shift_reg[FRAME_BITS-2:0], miso_in};
    end
  end

endmodule

// File: src/motor_pkg.sv
package motor_pkg;

  // One SPI frame is an address byte followed by 32 data bits
  localparam int FRAME_BITS = 40;

  typedef logic [FRAME_BITS-1:0] frame_t;

  // Status byte returned in the first 8 bits of every reply
  typedef logic [7:0] status_t;

  // Step half period in system clocks
  typedef logic [63:0] speed_t;

  // One state per register write and a final resting state
  typedef enum logic [2:0] {
    chop_conf,
    ihold_irun,
    tpower_down,
    en_pwm_mode,
    tpwm_thrs,
    pwm_conf,
    setup_done
  } setup_state_t;

  // Register writes in the order of setup_state_t
  // Bit 7 of the address byte marks a write access
  localparam frame_t SETUP_WORDS [0:5] = '{
    // CHOPCONF with TOFF 3 and HSTRT 4 and HEND 1 and TBL 2 in spreadCycle mode
    40'hEC000100C3,
    // IHOLD_IRUN with hold current 10 and run current 31 and hold delay 6
    40'h9000061F0A,
    // TPOWERDOWN delay of 10 before standstill current reduction
    40'h910000000A,
    // GCONF with en_pwm_mode set to select stealthChop
    40'h8000000004,
    // TPWMTHRS of 500 as the stealthChop upper velocity limit
    40'h93000001F4,
    // PWMCONF with automatic scaling and amplitude 200 and gradient 1
    40'hF0000401C8
  };

endpackage
